// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_dcache
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
dcache_pkg.sv
dcache_req_buf.sv
dcache_tagv.sv
dcache_data.sv
dcache_lru.sv
dcache_fsm.sv
dcache_top.sv
tb_dcache.sv

// File: dcache_data.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_data import dcache_pkg::*; (
    input  logic                clk,
    input  logic                rd_en,
    input  dcache_addr_u        rd_addr,
    input  dcache_addr_u        buf_addr,
    input  logic [num_ways-1:0] we,
    input  logic                refill,
    input  logic [31:0]         wdata,
    input  logic [3:0]          wstrb,
    input  logic [31:0]         mem_rdata,
    output logic [31:0]         way0_word,
    output logic [31:0]         way1_word
);

    logic [31:0] words [num_ways][num_sets];
    logic [31:0] new_word [num_ways];
    logic [31:0] rd_word [num_ways];
    logic        same_idx;

    assign same_idx = rd_addr.acc.index == buf_addr.acc.index;

    ////////////////////
    // write word: refill or byte merge
    ////////////////////
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            new_word[w] = words[w][buf_addr.acc.index];
            if (refill) begin
                new_word[w] = mem_rdata;
            end else begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) new_word[w][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (we[w]) words[w][buf_addr.acc.index] <= new_word[w];
            // write-first when the next request reads the set being written
            if (rd_en) begin
                rd_word[w] <= (we[w] && same_idx) ? new_word[w]
                                                  : words[w][rd_addr.acc.index];
            end
        end
    end

    assign way0_word = rd_word[0];
    assign way1_word = rd_word[1];

endmodule

`default_nettype wire

// File: dcache_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_fsm import dcache_pkg::*; (
    input  logic                clk,
    input  logic                rstn,
    input  logic                req_valid,
    input  logic                req_op,
    input  logic                buf_write,
    input  logic                buf_suc,
    input  logic [1:0]          buf_opcode,
    input  logic                buf_way,
    input  logic [num_ways-1:0] hit,
    input  logic                victim,
    input  logic                mem_addr_ok,
    input  logic                mem_data_ok,
    output logic                req_ready,
    output logic                buf_we,
    output logic                mem_req,
    output logic                mem_wr,
    output logic                resp_valid,
    output logic                op_ack,
    output logic [num_ways-1:0] data_we,
    output logic [num_ways-1:0] tagv_inv,
    output logic [1:0]          tagv_init,
    output logic                data_refill,
    output logic                use0,
    output logic                use1,
    output logic                choose_way,
    output logic                choose_return
);

    fsm_state_t          state;
    fsm_state_t          next_state;
    fsm_state_t          accept_state;
    logic                miss;
    logic [num_ways-1:0] hit_one;

    // uncached requests are treated as misses
    assign miss    = ~|hit || buf_suc;
    assign hit_one = hit[0] ? 2'b01 : {hit[1], 1'b0};

    // where to go when a new request may be taken
    assign accept_state = !req_valid ? idle : (req_op ? operation : lookup);

    // buffer and arrays capture whenever the pipeline sees ready
    assign buf_we = req_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    ////////////////////
    // next state
    ////////////////////
    always_comb begin
        next_state = state;
        case (state)
            idle:      next_state = accept_state;
            operation: next_state = accept_state;
            lookup: begin
                if (buf_write) begin
                    if (mem_addr_ok) next_state = accept_state;
                    else next_state = miss ? miss_w : hit_w;
                end else if (miss) begin
                    next_state = mem_addr_ok ? miss_r_wait : miss_r;
                end else begin
                    next_state = accept_state;
                end
            end
            hit_w, miss_w: if (mem_addr_ok) next_state = accept_state;
            miss_r:        if (mem_addr_ok) next_state = miss_r_wait;
            miss_r_wait:   if (mem_data_ok) next_state = miss_r_done;
            miss_r_done:   next_state = accept_state;
            default:       next_state = idle;
        endcase
    end

    ////////////////////
    // outputs
    ////////////////////
    always_comb begin
        req_ready     = 1'b0;
        mem_req       = 1'b0;
        mem_wr        = 1'b0;
        resp_valid    = 1'b0;
        op_ack        = 1'b0;
        data_we       = '0;
        tagv_inv      = '0;
        tagv_init     = '0;
        data_refill   = 1'b0;
        use0          = 1'b0;
        use1          = 1'b0;
        choose_way    = 1'b0;
        choose_return = 1'b0;
        case (state)
            idle: req_ready = 1'b1;
            lookup: begin
                // uncached access drops any matching line
                if (buf_suc) tagv_inv = hit_one;
                if (!miss) begin
                    use0 = hit_one[0];
                    use1 = hit_one[1];
                end
                if (buf_write) begin
                    mem_req   = 1'b1;
                    mem_wr    = 1'b1;
                    req_ready = mem_addr_ok;
                    if (!miss) data_we = hit_one;
                end else if (miss) begin
                    mem_req = 1'b1;
                end else begin
                    resp_valid = 1'b1;
                    req_ready  = 1'b1;
                    choose_way = hit_one[1];
                end
            end
            operation: begin
                req_ready = 1'b1;
                op_ack    = 1'b1;
                case (buf_opcode)
                    op_init:      tagv_init = {1'b1, buf_way};
                    op_index_inv: tagv_inv = buf_way ? 2'b10 : 2'b01;
                    op_hit_inv:   tagv_inv = hit_one;
                    default:      ;
                endcase
            end
            hit_w, miss_w: begin
                mem_req   = 1'b1;
                mem_wr    = 1'b1;
                req_ready = mem_addr_ok;
            end
            miss_r: mem_req = 1'b1;
            miss_r_wait: begin
                if (mem_data_ok) begin
                    resp_valid    = 1'b1;
                    choose_return = 1'b1;
                    data_refill   = 1'b1;
                    // no fill for strongly-ordered reads
                    if (!buf_suc) begin
                        data_we = victim ? 2'b10 : 2'b01;
                        use0    = !victim;
                        use1    = victim;
                    end
                end
            end
            miss_r_done: req_ready = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: dcache_lru.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_lru import dcache_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [index_width-1:0] index,
    input  logic                   use0,
    input  logic                   use1,
    output logic                   victim
);

    // one bit per set, names the way to replace next
    logic [num_sets-1:0] lru;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru <= '0;
        end else if (use0) begin
            lru[index] <= 1'b1;
        end else if (use1) begin
            lru[index] <= 1'b0;
        end
    end

    assign victim = lru[index];

endmodule

`default_nettype wire

// File: dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // cache geometry, one word per line
    localparam int num_sets    = 16;
    localparam int index_width = 4;
    localparam int tag_width   = 26;
    localparam int num_ways    = 2;

    // maintenance opcodes
    localparam logic [1:0] op_init      = 2'd0;
    localparam logic [1:0] op_index_inv = 2'd1;
    localparam logic [1:0] op_hit_inv   = 2'd2;

    typedef enum logic [2:0] {
        idle, lookup, operation, hit_w, miss_r, miss_r_wait, miss_r_done, miss_w
    } fsm_state_t;

    // same word seen as a load/store address or as a maintenance target
    typedef union packed {
        struct packed {
            logic [tag_width-1:0]   tag;
            logic [index_width-1:0] index;
            logic [1:0]             offset;
        } acc;
        struct packed {
            logic [tag_width-1:0]   upper;
            logic [index_width-1:0] index;
            logic                   pad;
            logic                   way;
        } mnt;
    } dcache_addr_u;

endpackage

`default_nettype wire

// File: dcache_req_buf.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_req_buf import dcache_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    input  logic         we,
    input  dcache_addr_u addr,
    input  logic [31:0]  wdata,
    input  logic [3:0]   wstrb,
    input  logic         write,
    input  logic         suc,
    input  logic [1:0]   opcode,
    output dcache_addr_u buf_addr,
    output logic [31:0]  buf_wdata,
    output logic [3:0]   buf_wstrb,
    output logic         buf_write,
    output logic         buf_suc,
    output logic [1:0]   buf_opcode
);

    // holds the request while the controller works on it
    always_ff @(posedge clk) begin
        if (!rstn) begin
            buf_addr   <= '0;
            buf_wdata  <= '0;
            buf_wstrb  <= '0;
            buf_write  <= 1'b0;
            buf_suc    <= 1'b0;
            buf_opcode <= '0;
        end else if (we) begin
            buf_addr   <= addr;
            buf_wdata  <= wdata;
            buf_wstrb  <= wstrb;
            buf_write  <= write;
            buf_suc    <= suc;
            buf_opcode <= opcode;
        end
    end

endmodule

`default_nettype wire

// File: dcache_tagv.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tagv import dcache_pkg::*; (
    input  logic                clk,
    input  logic                rstn,
    input  logic                rd_en,
    input  dcache_addr_u        rd_addr,
    input  dcache_addr_u        buf_addr,
    input  logic [num_ways-1:0] we,
    input  logic [num_ways-1:0] inv,
    input  logic [1:0]          init,
    output logic [num_ways-1:0] hit
);

    logic [tag_width-1:0]   tags [num_ways][num_sets];
    logic [num_sets-1:0]    valid [num_ways];
    logic [tag_width-1:0]   tag_q [num_ways];
    logic [num_ways-1:0]    valid_q;
    logic [tag_width-1:0]   nxt_tag [num_ways];
    logic [num_ways-1:0]    nxt_valid;
    logic [num_ways-1:0]    tag_we;
    logic [index_width-1:0] wr_idx;
    logic                   same_idx;

    // maintenance target and access index share the same bits
    assign wr_idx   = buf_addr.mnt.index;
    assign same_idx = rd_addr.acc.index == wr_idx;

    // next tag/valid of the buffered set, per way
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            nxt_tag[w]   = tags[w][wr_idx];
            nxt_valid[w] = valid[w][wr_idx];
            tag_we[w]    = 1'b0;
            if (init[1] && init[0] == w[0]) begin
                nxt_tag[w]   = '0;
                nxt_valid[w] = 1'b0;
                tag_we[w]    = 1'b1;
            end else if (inv[w]) begin
                nxt_valid[w] = 1'b0;
            end else if (we[w]) begin
                nxt_tag[w]   = buf_addr.acc.tag;
                nxt_valid[w] = 1'b1;
                tag_we[w]    = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (tag_we[w]) tags[w][wr_idx] <= nxt_tag[w];
            // forward an update made in the same cycle as the read
            if (rd_en) tag_q[w] <= same_idx ? nxt_tag[w] : tags[w][rd_addr.acc.index];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int w = 0; w < num_ways; w++) valid[w] <= '0;
            valid_q <= '0;
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                valid[w][wr_idx] <= nxt_valid[w];
                if (rd_en) valid_q[w] <= same_idx ? nxt_valid[w] : valid[w][rd_addr.acc.index];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit[w] = valid_q[w] && (tag_q[w] == buf_addr.acc.tag);
        end
    end

endmodule

`default_nettype wire

// File: dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        req_valid,
    input  logic        req_write,
    input  logic        req_suc,
    input  logic        req_op,
    input  logic [1:0]  req_opcode,
    input  logic [31:0] req_addr,
    input  logic [31:0] req_wdata,
    input  logic [3:0]  req_wstrb,
    output logic        req_ready,
    output logic        resp_valid,
    output logic [31:0] resp_rdata,
    output logic        op_ack,
    output logic        mem_req,
    output logic        mem_wr,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    output logic [3:0]  mem_wstrb,
    input  logic        mem_addr_ok,
    input  logic [31:0] mem_rdata,
    input  logic        mem_data_ok
);

    dcache_addr_u        req_addr_u;
    dcache_addr_u        buf_addr;
    logic [31:0]         buf_wdata;
    logic [3:0]          buf_wstrb;
    logic                buf_write;
    logic                buf_suc;
    logic [1:0]          buf_opcode;
    logic                buf_we;
    logic [num_ways-1:0] hit;
    logic                victim;
    logic [num_ways-1:0] data_we;
    logic [num_ways-1:0] tagv_inv;
    logic [1:0]          tagv_init;
    logic                data_refill;
    logic                use0;
    logic                use1;
    logic                choose_way;
    logic                choose_return;
    logic [31:0]         way0_word;
    logic [31:0]         way1_word;

    assign req_addr_u = req_addr;

    dcache_req_buf u_req_buf (
        .clk(clk), .rstn(rstn), .we(buf_we), .addr(req_addr_u),
        .wdata(req_wdata), .wstrb(req_wstrb), .write(req_write),
        .suc(req_suc), .opcode(req_opcode), .buf_addr(buf_addr),
        .buf_wdata(buf_wdata), .buf_wstrb(buf_wstrb), .buf_write(buf_write),
        .buf_suc(buf_suc), .buf_opcode(buf_opcode)
    );

    // tag array is written with the same enables as the data array
    dcache_tagv u_tagv (
        .clk(clk), .rstn(rstn), .rd_en(buf_we), .rd_addr(req_addr_u),
        .buf_addr(buf_addr), .we(data_we), .inv(tagv_inv), .init(tagv_init),
        .hit(hit)
    );

    dcache_data u_data (
        .clk(clk), .rd_en(buf_we), .rd_addr(req_addr_u), .buf_addr(buf_addr),
        .we(data_we), .refill(data_refill), .wdata(buf_wdata),
        .wstrb(buf_wstrb), .mem_rdata(mem_rdata),
        .way0_word(way0_word), .way1_word(way1_word)
    );

    dcache_lru u_lru (
        .clk(clk), .rstn(rstn), .index(buf_addr.acc.index),
        .use0(use0), .use1(use1), .victim(victim)
    );

    dcache_fsm u_fsm (
        .clk(clk), .rstn(rstn), .req_valid(req_valid), .req_op(req_op),
        .buf_write(buf_write), .buf_suc(buf_suc), .buf_opcode(buf_opcode),
        .buf_way(buf_addr.mnt.way), .hit(hit), .victim(victim),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok),
        .req_ready(req_ready), .buf_we(buf_we), .mem_req(mem_req),
        .mem_wr(mem_wr), .resp_valid(resp_valid), .op_ack(op_ack),
        .data_we(data_we), .tagv_inv(tagv_inv), .tagv_init(tagv_init),
        .data_refill(data_refill), .use0(use0), .use1(use1),
        .choose_way(choose_way), .choose_return(choose_return)
    );

    // memory word on a refill, otherwise the hitting way
    assign resp_rdata = choose_return ? mem_rdata
                      : (choose_way ? way1_word : way0_word);

    assign mem_addr  = buf_addr;
    assign mem_wdata = buf_wdata;
    assign mem_wstrb = buf_wstrb;

endmodule

`default_nettype wire

// File: tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache import dcache_pkg::*; ();

    localparam int wait_limit = 64;
    localparam int num_random = 3000;
    localparam logic [1:0] k_load  = 2'd0;
    localparam logic [1:0] k_store = 2'd1;
    localparam logic [1:0] k_op    = 2'd2;

    logic        clk;
    logic        rstn;
    logic        req_valid;
    logic        req_write;
    logic        req_suc;
    logic        req_op;
    logic [1:0]  req_opcode;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic [3:0]  req_wstrb;
    logic        req_ready;
    logic        resp_valid;
    logic [31:0] resp_rdata;
    logic        op_ack;
    logic        mem_req;
    logic        mem_wr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;
    logic        mem_addr_ok;
    logic [31:0] mem_rdata;
    logic        mem_data_ok;

    // reference model of the cache contents
    logic [tag_width-1:0] m_tag [num_ways][num_sets];
    logic                 m_valid [num_ways][num_sets];
    logic                 m_lru [num_sets];
    logic [31:0]          shadow [logic [31:0]];
    logic [31:0]          mem_words [logic [31:0]];
    logic [31:0]          exp_words [$];
    logic [31:0]          exp_word;
    logic [31:0]          stim_rng;
    logic [31:0]          mem_rng;
    logic                 lat_hit;
    logic                 aborted;
    int                   lat_kind;
    int                   mismatches;
    int                   failures;
    int                   ops_issued;
    int                   acks_seen;

    dcache_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // memory contents before any write
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h6b2e_91d4;
    endfunction

    function automatic logic [31:0] mem_fetch(input logic [31:0] a);
        if (mem_words.exists({a[31:2], 2'b00})) return mem_words[{a[31:2], 2'b00}];
        return fill_word({a[31:2], 2'b00});
    endfunction

    function automatic logic [31:0] shadow_fetch(input logic [31:0] a);
        if (shadow.exists({a[31:2], 2'b00})) return shadow[{a[31:2], 2'b00}];
        return fill_word({a[31:2], 2'b00});
    endfunction

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                          input logic [3:0] strb);
        logic [31:0] w;
        w = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) w[8*b +: 8] = data[8*b +: 8];
        end
        return w;
    endfunction

    function automatic logic [31:0] addr_of(input int t, input int i);
        return {26'h00_01c0 + 26'(t), 4'(i), 2'b00};
    endfunction

    // matching way of the model or -1
    function automatic int find_way(input logic [31:0] addr);
        for (int w = 0; w < num_ways; w++) begin
            if (m_valid[w][addr[5:2]] && m_tag[w][addr[5:2]] == addr[31:6]) return w;
        end
        return -1;
    endfunction

    // expected load word and whether the cache answers it by itself
    function automatic logic [31:0] ref_load(input logic [31:0] addr, input logic suc,
                                             output logic hit);
        hit = !suc && find_way(addr) >= 0;
        return shadow_fetch(addr);
    endfunction

    function automatic void update_model(input logic [1:0] kind, input logic [31:0] addr,
                                         input logic suc, input logic [31:0] wdata,
                                         input logic [3:0] wstrb, input logic [1:0] opcode);
        int w;
        int idx;
        w = find_way(addr);
        idx = int'(addr[5:2]);
        if (kind == k_op) begin
            if (opcode == op_init) begin
                m_valid[addr[0]][idx] = 1'b0;
                m_tag[addr[0]][idx] = '0;
            end else if (opcode == op_index_inv) begin
                m_valid[addr[0]][idx] = 1'b0;
            end else if (opcode == op_hit_inv && w >= 0) begin
                m_valid[w][idx] = 1'b0;
            end
        end else if (suc) begin
            if (w >= 0) m_valid[w][idx] = 1'b0;
        end else if (w >= 0) begin
            m_lru[idx] = (w == 0);
        end else if (kind == k_load) begin
            // refill into the victim while store misses do not allocate
            m_tag[m_lru[idx]][idx] = addr[31:6];
            m_valid[m_lru[idx]][idx] = 1'b1;
            m_lru[idx] = !m_lru[idx];
        end
        if (kind == k_store) shadow[{addr[31:2], 2'b00}] = merge(shadow_fetch(addr), wdata, wstrb);
    endfunction

    ////////////////////
    // memory model
    ////////////////////
    initial begin
        int          addr_wait;
        int          data_wait;
        logic        rd_busy;
        logic [31:0] rd_addr;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata = '0;
        mem_rng = 32'ha7780411;
        addr_wait = -1;
        data_wait = 0;
        rd_busy = 1'b0;
        rd_addr = '0;
        forever begin
            @(posedge clk);
            #1;
            mem_addr_ok = 1'b0;
            mem_data_ok = 1'b0;
            mem_rdata = 32'h0bad_f00d;
            if (!rstn) begin
                addr_wait = -1;
                rd_busy = 1'b0;
            end else if (rd_busy) begin
                if (data_wait == 0) begin
                    mem_data_ok = 1'b1;
                    mem_rdata = mem_fetch(rd_addr);
                    rd_busy = 1'b0;
                end else begin
                    data_wait--;
                end
            end else if (mem_req) begin
                if (addr_wait < 0) begin
                    mem_rng = xorshift(mem_rng);
                    addr_wait = int'(mem_rng[1:0]);
                end
                if (addr_wait == 0) begin
                    mem_addr_ok = 1'b1;
                    addr_wait = -1;
                    if (mem_wr) begin
                        mem_words[{mem_addr[31:2], 2'b00}] =
                            merge(mem_fetch(mem_addr), mem_wdata, mem_wstrb);
                    end else begin
                        rd_busy = 1'b1;
                        rd_addr = mem_addr;
                        data_wait = int'(mem_rng[3:2]);
                    end
                end else begin
                    addr_wait--;
                end
            end
        end
    end

    ////////////////////
    // response compare
    ////////////////////
    always @(negedge clk) begin
        if (rstn) begin
            if (resp_valid) begin
                assert (exp_words.size() != 0) else begin
                    failures++;
                    $display("error at %0t: response without an outstanding load", $time);
                end
                if (exp_words.size() != 0) begin
                    exp_word = exp_words.pop_front();
                    assert (resp_rdata == exp_word) else begin
                        mismatches++;
                        $display("mismatch at %0t: resp_rdata expected %h, got %h",
                                 $time, exp_word, resp_rdata);
                    end
                end
            end
            if (op_ack) acks_seen++;
            // first cycle after acceptance
            if (lat_kind == 1) begin
                assert (resp_valid == lat_hit) else begin
                    mismatches++;
                    $display("mismatch at %0t: resp_valid expected %0b, got %0b",
                             $time, lat_hit, resp_valid);
                end
                assert (mem_req == !lat_hit) else begin
                    mismatches++;
                    $display("mismatch at %0t: mem_req expected %0b, got %0b",
                             $time, !lat_hit, mem_req);
                end
            end else if (lat_kind == 2) begin
                assert (op_ack) else begin
                    mismatches++;
                    $display("mismatch at %0t: op_ack expected 1, got %0b", $time, op_ack);
                end
            end else if (lat_kind == 3) begin
                assert (mem_wr) else begin
                    mismatches++;
                    $display("mismatch at %0t: mem_wr expected 1, got %0b", $time, mem_wr);
                end
            end
            lat_kind = 0;
        end
    end

    task automatic issue(input logic [1:0] kind, input logic [31:0] addr, input logic suc,
                         input logic [31:0] wdata, input logic [3:0] wstrb,
                         input logic [1:0] opcode);
        int          waited;
        logic        hit;
        logic [31:0] word;
        if (aborted) return;
        req_valid  = 1'b1;
        req_write  = kind == k_store;
        req_op     = kind == k_op;
        req_suc    = suc;
        req_addr   = addr;
        req_wdata  = wdata;
        req_wstrb  = wstrb;
        req_opcode = opcode;
        waited = 0;
        @(negedge clk);
        while (!req_ready && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        assert (req_ready) else begin
            failures++;
            $display("timeout at %0t: request to %h was never accepted", $time, addr);
            aborted = 1'b1;
        end
        if (!aborted) begin
            @(posedge clk);
            #1;
            req_valid = 1'b0;
            if (kind == k_load) begin
                word = ref_load(addr, suc, hit);
                exp_words.push_back(word);
                lat_hit = hit;
                lat_kind = 1;
            end else if (kind == k_op) begin
                ops_issued++;
                lat_kind = 2;
            end else begin
                lat_kind = 3;
            end
            update_model(kind, addr, suc, wdata, wstrb, opcode);
        end
    endtask

    initial begin
        int          t;
        int          i;
        int          sel;
        int          opc;
        int          waited;
        logic [31:0] r;
        logic [31:0] wd;
        rstn = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_suc = 1'b0;
        req_op = 1'b0;
        req_opcode = '0;
        req_addr = '0;
        req_wdata = '0;
        req_wstrb = '0;
        stim_rng = 32'ha7780411;
        lat_kind = 0;
        lat_hit = 1'b0;
        aborted = 1'b0;
        mismatches = 0;
        failures = 0;
        ops_issued = 0;
        acks_seen = 0;
        for (int s = 0; s < num_sets; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_lru[s] = 1'b0;
        end
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        assert (req_ready && !mem_req && !resp_valid && !op_ack) else begin
            failures++;
            $display("error at %0t: outputs are not in their idle state after reset", $time);
        end
        @(posedge clk);
        #1;

        // two tags fill set 0 and a third evicts the lru way
        issue(k_load, addr_of(0, 0), 1'b0, '0, '0, '0);
        issue(k_load, addr_of(0, 0), 1'b0, '0, '0, '0);
        issue(k_load, addr_of(1, 0), 1'b0, '0, '0, '0);
        issue(k_load, addr_of(2, 0), 1'b0, '0, '0, '0);
        issue(k_load, addr_of(0, 0), 1'b0, '0, '0, '0);
        // store miss does not allocate
        issue(k_store, addr_of(1, 1), 1'b0, 32'h1122_3344, 4'b0101, '0);
        issue(k_load, addr_of(1, 1), 1'b0, '0, '0, '0);
        // uncached loads
        issue(k_load, addr_of(2, 2), 1'b1, '0, '0, '0);
        issue(k_load, addr_of(2, 2), 1'b1, '0, '0, '0);
        issue(k_load, addr_of(2, 2), 1'b0, '0, '0, '0);
        // maintenance on set 3
        issue(k_load, addr_of(0, 3), 1'b0, '0, '0, '0);
        issue(k_op, addr_of(0, 3), 1'b0, '0, '0, op_hit_inv);
        issue(k_load, addr_of(0, 3), 1'b0, '0, '0, '0);
        // the refill above went to way 1
        issue(k_op, addr_of(0, 3) | 32'd1, 1'b0, '0, '0, op_index_inv);
        issue(k_load, addr_of(0, 3), 1'b0, '0, '0, '0);
        issue(k_op, addr_of(0, 3), 1'b0, '0, '0, op_init);
        issue(k_op, addr_of(0, 3) | 32'd1, 1'b0, '0, '0, op_init);
        issue(k_load, addr_of(0, 3), 1'b0, '0, '0, '0);

        for (int n = 0; n < num_random && !aborted; n++) begin
            stim_rng = xorshift(stim_rng);
            r = stim_rng;
            stim_rng = xorshift(stim_rng);
            wd = stim_rng;
            t = int'(r[1:0]) % 3;
            i = int'(r[3:2]);
            sel = int'(r[7:4]);
            opc = int'(r[10:9]) % 3;
            if (sel < 7) begin
                issue(k_load, addr_of(t, i), 1'b0, '0, '0, '0);
            end else if (sel < 11) begin
                issue(k_store, addr_of(t, i), 1'b0, wd, r[14:11], '0);
            end else if (sel == 11) begin
                issue(k_load, addr_of(t, i), 1'b1, '0, '0, '0);
            end else if (sel == 12) begin
                issue(k_store, addr_of(t, i), 1'b1, wd, r[14:11], '0);
            end else begin
                issue(k_op, addr_of(t, i) | 32'(r[8]), 1'b0, '0, '0, 2'(opc));
            end
        end

        // let the last responses come back
        waited = 0;
        while ((exp_words.size() != 0 || lat_kind != 0) && waited < wait_limit && !aborted) begin
            @(posedge clk);
            waited++;
        end
        assert (aborted || exp_words.size() == 0) else begin
            failures++;
            $display("timeout at %0t: %0d load responses never arrived", $time,
                     exp_words.size());
        end
        assert (acks_seen == ops_issued) else begin
            mismatches++;
            $display("mismatch at %0t: op_ack count expected %0d, got %0d",
                     $time, ops_issued, acks_seen);
        end

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
